//--- Bender.yml
package:
  name: lsu_mem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_mem_pkg.sv
      - design/lsu_fifo.sv
      - design/store_align.sv
      - design/load_extract.sv
      - design/data_ram.sv
      - design/lsu_ctrl.sv
      - design/lsu_mem_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_lsu_mem.sv

//--- design/data_ram.sv
//////////////////////////////////////////////////
// data_ram: word RAM with byte write enables
// Registered read, contents start at zero
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_mem_defs.svh"

module data_ram (
  input  logic                  clk,
  input  lsu_mem_pkg::ram_cmd_t cmd,
  output logic [31:0]           rdata
);

  localparam int WORDS = `LSU_MEM_BYTES / 4;

  // Four byte lanes per word, not touched by reset
  logic [3:0][7:0] mem [WORDS] = '{default: '0};

  // Write lands at the command edge
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (cmd.we && cmd.be[b]) begin
        mem[cmd.idx][b] <= cmd.wdata[8*b +: 8];
      end
    end
  end

  // Read data valid one cycle after the command, old data on a same-word write
  always_ff @(posedge clk) begin
    rdata <= mem[cmd.idx];
  end

  // Controller only raises enables on a write
  a_be_needs_we : assert property (@(posedge clk) (|cmd.be) |-> cmd.we)
    else $error("data_ram: byte enable without write");

endmodule

//--- design/load_extract.sv
//////////////////////////////////////////////////
// load_extract: lane select and sign/zero extend
// Zero for stores and errored accesses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module load_extract (
  input  logic [31:0]            word,
  input  lsu_mem_pkg::load_tag_t tag,
  output logic [31:0]            data
);

  import lsu_mem_pkg::*;

  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  // Addressed byte and halfword from the RAM word
  always_comb begin
    case (tag.offset)
      2'd0:    lane_b = word[7:0];
      2'd1:    lane_b = word[15:8];
      2'd2:    lane_b = word[23:16];
      default: lane_b = word[31:24];
    endcase
    lane_h = tag.offset[1] ? word[31:16] : word[15:0];  // Offset 0 or 2 only
  end

  always_comb begin
    if (tag.err || tag.store) begin
      data = 32'h0;  // Ack or error carries no data
    end else begin
      case (tag.funct3)
        F3_B:    data = {{24{lane_b[7]}}, lane_b};
        F3_H:    data = {{16{lane_h[15]}}, lane_h};
        F3_W:    data = word;
        F3_BU:   data = {24'h0, lane_b};
        F3_HU:   data = {16'h0, lane_h};
        default: data = 32'h0;
      endcase
    end
  end

endmodule

//--- design/lsu_ctrl.sv
//////////////////////////////////////////////////
// lsu_ctrl: request check and RAM issue
// Credit against response queue, one tag stage
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_mem_defs.svh"

module lsu_ctrl (
  input  logic                              clk,
  input  logic                              arst_n,
  input  lsu_mem_pkg::mem_req_t             req_data,
  input  logic                              req_empty,
  output logic                              req_pop,
  input  logic [lsu_mem_pkg::QCNT_W-1:0]    rsp_free,
  output logic                              rsp_push,
  output lsu_mem_pkg::mem_rsp_t             rsp_data,
  output lsu_mem_pkg::mem_req_t             st_req,
  input  logic [31:0]                       st_lanes,
  input  logic [3:0]                        st_be,
  output lsu_mem_pkg::ram_cmd_t             ram_cmd,
  output lsu_mem_pkg::load_tag_t            ld_tag,
  input  logic [31:0]                       ld_data
);

  import lsu_mem_pkg::*;

  localparam logic [`LSU_ADDR_W-1:0] ADDR_MASK = `LSU_MEM_BYTES - 1;

  logic [`LSU_ADDR_W-1:0] masked_addr;
  logic                   acc_err;     // Misaligned or bad funct3
  logic                   do_write;
  logic [QCNT_W-1:0]      inflight_q;  // Popped, response not yet pushed

  assign masked_addr = req_data.addr & ADDR_MASK;  // Wrap onto RAM size

  // Alignment and funct3 legality
  always_comb begin
    case (req_data.funct3)
      F3_B:    acc_err = 1'b0;
      F3_H:    acc_err = req_data.addr[0];
      F3_W:    acc_err = |req_data.addr[1:0];
      F3_BU:   acc_err = req_data.store;                     // No unsigned stores
      F3_HU:   acc_err = req_data.store || req_data.addr[0];
      default: acc_err = 1'b1;
    endcase
  end

  // Pop only with a guaranteed response slot next cycle
  assign req_pop  = !req_empty && (rsp_free > inflight_q);
  assign do_write = req_pop && req_data.store && !acc_err;

  // Store path sees the masked address
  always_comb begin
    st_req      = req_data;
    st_req.addr = masked_addr;
  end

  // RAM command, a read whenever we is low
  always_comb begin
    ram_cmd.idx   = masked_addr[WORD_IDX_W+1:2];
    ram_cmd.wdata = st_lanes;
    ram_cmd.we    = do_write;
    ram_cmd.be    = do_write ? st_be : 4'b0000;  // Error leaves RAM alone
  end

  // Tag lines up with the registered RAM read
  always_ff @(posedge clk) begin
    if (req_pop) begin
      ld_tag <= '{offset: masked_addr[1:0],
                  funct3: req_data.funct3,
                  err:    acc_err,
                  store:  req_data.store};
    end
  end

  // In-flight credit, each pop is pushed exactly one cycle later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      inflight_q <= '0;
    end else begin
      case ({req_pop, rsp_push})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  assign rsp_push = (inflight_q != '0);
  assign rsp_data = '{data: ld_data, err: ld_tag.err};  // ld_data already zero on err/store

  // Credit must cover every push into the response queue
  a_push_has_room : assert property (@(posedge clk) disable iff (!arst_n)
    rsp_push |-> (rsp_free != '0))
    else $error("lsu_ctrl: response push without free slot");

endmodule

//--- design/lsu_fifo.sv
//////////////////////////////////////////////////
// lsu_fifo: register-array queue, payload by type
// Used for both request and response streams
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_fifo #(
  parameter type T         = logic,
  parameter int  DEPTH     = 2,
  localparam int CNT_W     = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             push,
  input  T                 push_data,
  output logic             full,
  input  logic             pop,
  output T                 pop_data,
  output logic             empty,
  output logic [CNT_W-1:0] free_count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 store_q [DEPTH];  // Payload slots
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign full       = (count == CNT_W'(DEPTH));
  assign empty      = (count == '0);
  assign free_count = CNT_W'(DEPTH) - count;
  assign pop_data   = store_q[rd_ptr];  // Head visible without a pop

  // Pointers and fill level
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  // Payload, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      store_q[wr_ptr] <= push_data;
    end
  end

  // Producer and consumer must honour full/empty
  a_no_push_full : assert property (@(posedge clk) disable iff (!arst_n) !(push && full))
    else $error("lsu_fifo: push while full");
  a_no_pop_empty : assert property (@(posedge clk) disable iff (!arst_n) !(pop && empty))
    else $error("lsu_fifo: pop while empty");

endmodule

//--- design/lsu_mem_defs.svh
//////////////////////////////////////////////////
// Build-time sizes of the data memory subsystem
// Memory bytes, address width, queue depth
//////////////////////////////////////////////////

`ifndef LSU_MEM_DEFS_SVH
`define LSU_MEM_DEFS_SVH

// Memory size in bytes, must be a power of two
`define LSU_MEM_BYTES 4096

// Core byte address width
`define LSU_ADDR_W 32

// Entries in each of the request and response queues
`define LSU_QUEUE_DEPTH 2

`endif

//--- design/lsu_mem_pkg.sv
//////////////////////////////////////////////////
// Shared types of the data memory subsystem
// funct3 codes, request/response, RAM command, tag
//////////////////////////////////////////////////

`include "lsu_mem_defs.svh"

package lsu_mem_pkg;

  localparam int WORD_IDX_W = $clog2(`LSU_MEM_BYTES / 4);  // RAM word index bits
  localparam int QCNT_W     = $clog2(`LSU_QUEUE_DEPTH + 1); // Queue fill/free count bits

  // RV32I load/store funct3, other codes are illegal
  typedef enum logic [2:0] {
    F3_B  = 3'b000,  // LB / SB
    F3_H  = 3'b001,  // LH / SH
    F3_W  = 3'b010,  // LW / SW
    F3_BU = 3'b100,  // LBU
    F3_HU = 3'b101   // LHU
  } mem_funct3_e;

  // Core side request, 68 bits
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;    // Byte address, unmasked
    logic [31:0]            wdata;   // Store data, low bits used for SB/SH
    mem_funct3_e            funct3;
    logic                   store;   // 1 store, 0 load
  } mem_req_t;

  // Core side response, 33 bits
  typedef struct packed {
    logic [31:0] data;  // Extended load data, zero otherwise
    logic        err;   // Misaligned or illegal funct3
  } mem_rsp_t;

  // One RAM access per cycle
  typedef struct packed {
    logic [WORD_IDX_W-1:0] idx;    // Word index
    logic [31:0]           wdata;  // Data already on its byte lanes
    logic [3:0]            be;     // Byte enables, only with we
    logic                  we;
  } ram_cmd_t;

  // Follows a RAM read by one cycle
  typedef struct packed {
    logic [1:0]  offset;  // Byte offset in the word
    mem_funct3_e funct3;
    logic        err;
    logic        store;
  } load_tag_t;

endpackage

//--- design/lsu_mem_top.sv
//////////////////////////////////////////////////
// Top level of the data memory subsystem
// Request/response queues, control, datapath, RAM
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_mem_defs.svh"

module lsu_mem_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  req_valid,
  input  lsu_mem_pkg::mem_req_t req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output lsu_mem_pkg::mem_rsp_t rsp,
  input  logic                  rsp_ready
);

  import lsu_mem_pkg::*;

  mem_req_t          req_q;       // Head of request queue
  logic              req_full;
  logic              req_empty;
  logic              req_pop;
  logic              rsp_empty;
  logic [QCNT_W-1:0] rsp_free;
  logic              rsp_push;
  mem_rsp_t          rsp_push_data;
  mem_req_t          st_req;
  logic [31:0]       st_lanes;
  logic [3:0]        st_be;
  ram_cmd_t          ram_cmd;
  logic [31:0]       ram_rdata;
  load_tag_t         ld_tag;
  logic [31:0]       ld_data;

  assign req_ready = !req_full;
  assign rsp_valid = !rsp_empty;

  lsu_fifo #(.T(mem_req_t), .DEPTH(`LSU_QUEUE_DEPTH)) u_req_fifo (
    .clk, .arst_n,
    .push       (req_valid && req_ready),
    .push_data  (req),
    .full       (req_full),
    .pop        (req_pop),
    .pop_data   (req_q),
    .empty      (req_empty),
    .free_count ()                         // Not needed on the request side
  );

  lsu_ctrl u_ctrl (
    .clk, .arst_n,
    .req_data (req_q),    .req_empty, .req_pop,
    .rsp_free,            .rsp_push,  .rsp_data (rsp_push_data),
    .st_req,              .st_lanes,  .st_be,
    .ram_cmd,             .ld_tag,    .ld_data
  );

  store_align u_store_align (.req(st_req), .lanes(st_lanes), .be(st_be));

  data_ram u_data_ram (.clk, .cmd(ram_cmd), .rdata(ram_rdata));

  load_extract u_load_extract (.word(ram_rdata), .tag(ld_tag), .data(ld_data));

  lsu_fifo #(.T(mem_rsp_t), .DEPTH(`LSU_QUEUE_DEPTH)) u_rsp_fifo (
    .clk, .arst_n,
    .push       (rsp_push),
    .push_data  (rsp_push_data),
    .full       (),                        // Credit in lsu_ctrl keeps pushes off a full queue
    .pop        (rsp_valid && rsp_ready),
    .pop_data   (rsp),
    .empty      (rsp_empty),
    .free_count (rsp_free)
  );

endmodule

//--- design/store_align.sv
//////////////////////////////////////////////////
// store_align: store data to byte lanes
// Byte enables from size and offset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module store_align (
  input  lsu_mem_pkg::mem_req_t req,
  output logic [31:0]           lanes,
  output logic [3:0]            be
);

  import lsu_mem_pkg::*;

  logic [1:0] offset;

  assign offset = req.addr[1:0];

  // Alignment is checked in lsu_ctrl, here it is assumed legal
  always_comb begin
    case (req.funct3)
      F3_B, F3_BU: begin
        lanes = {4{req.wdata[7:0]}};   // Byte copied to every lane
        be    = 4'b0001 << offset;
      end
      F3_H, F3_HU: begin
        lanes = {2{req.wdata[15:0]}};  // Halfword in both halves
        be    = offset[1] ? 4'b1100 : 4'b0011;
      end
      F3_W: begin
        lanes = req.wdata;
        be    = 4'b1111;
      end
      default: begin
        lanes = req.wdata;
        be    = 4'b0000;  // Illegal size writes nothing
      end
    endcase
  end

endmodule

//--- sim.f
+incdir+design
design/lsu_mem_pkg.sv
design/lsu_fifo.sv
design/store_align.sv
design/load_extract.sv
design/data_ram.sv
design/lsu_ctrl.sv
design/lsu_mem_top.sv
sim/tb_lsu_mem.sv

//--- sim/lsu_mem_input.txt
# store funct3 addr wdata exp_data exp_err, all fields hex, one access per line
# funct3 0 LB/SB, 1 LH/SH, 2 LW/SW, 4 LBU, 5 LHU, any other code is illegal
1 2 00000100 deadbeef 00000000 0  # SW
0 2 00000100 00000000 deadbeef 0  # LW same address
0 2 00001100 00000000 deadbeef 0  # LW alias above memory size
0 2 fffff100 00000000 deadbeef 0  # LW alias, high bits set
1 2 80000200 12345678 00000000 0  # SW through alias
0 2 00000200 00000000 12345678 0  # LW base address
1 2 00000300 11223344 00000000 0  # SW
1 0 00000301 000000aa 00000000 0  # SB byte 1
0 2 00000300 00000000 1122aa44 0  # Merged word
1 1 00000302 0000beef 00000000 0  # SH upper half
0 2 00000300 00000000 beefaa44 0  # Merged word
1 0 00000300 ffffff5a 00000000 0  # SB byte 0, upper wdata bits ignored
0 2 00000300 00000000 beefaa5a 0  # Merged word
0 0 00000300 00000000 0000005a 0  # LB positive
0 0 00000301 00000000 ffffffaa 0  # LB negative
0 4 00000301 00000000 000000aa 0  # LBU
0 0 00000303 00000000 ffffffbe 0  # LB top byte
0 4 00000302 00000000 000000ef 0  # LBU
0 1 00000300 00000000 ffffaa5a 0  # LH negative
0 5 00000300 00000000 0000aa5a 0  # LHU
0 1 00000302 00000000 ffffbeef 0  # LH upper half
0 5 00000302 00000000 0000beef 0  # LHU upper half
1 2 00000400 7f3c0102 00000000 0  # SW
0 1 00000400 00000000 00000102 0  # LH positive
0 1 00000402 00000000 00007f3c 0  # LH positive upper half
0 0 00000403 00000000 0000007f 0  # LB positive
0 4 00000403 00000000 0000007f 0  # LBU
1 1 00000401 0000ffff 00000000 1  # SH odd address
1 2 00000402 ffffffff 00000000 1  # SW not word aligned
0 1 00000403 00000000 00000000 1  # LH odd address
0 2 00000401 00000000 00000000 1  # LW not word aligned
0 5 00000405 00000000 00000000 1  # LHU odd address
0 3 00000400 00000000 00000000 1  # Illegal funct3 load
1 7 00000400 ffffffff 00000000 1  # Illegal funct3 store
0 2 00000400 00000000 7f3c0102 0  # Memory unchanged by errors
1 2 00000500 a5a5a5a5 00000000 0  # Back-to-back burst
1 2 00000504 5a5a5a5a 00000000 0
1 0 00000507 00000000 00000000 0  # SB clears top byte
0 2 00000504 00000000 005a5a5a 0
0 4 00000500 00000000 000000a5 0
0 2 00000500 00000000 a5a5a5a5 0

//--- sim/tb_lsu_mem.sv
//////////////////////////////////////////////////
// Testbench for the data memory subsystem
// Vector file driver, stalled response monitor
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lsu_mem;

  import lsu_mem_pkg::*;

  localparam int CLK_PERIOD = 40;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     req_valid;
  mem_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     rsp_ready;

  mem_req_t vec_req [$];  // Stimulus from the vector file
  mem_rsp_t vec_exp [$];  // Expected response per vector
  mem_rsp_t exp_q   [$];  // Accepted, response still due
  int       idx_q   [$];  // Vector number of each due response

  int seed         = 16041;
  int n_vec        = 0;
  int rsp_count    = 0;
  int stall_cycles = 0;  // Cycles with req_valid high and req_ready low
  int data_errs    = 0;
  int flag_errs    = 0;
  int other_errs   = 0;
  bit loaded       = 1'b0;

  lsu_mem_top u_dut (
    .clk, .arst_n,
    .req_valid, .req, .req_ready,
    .rsp_valid, .rsp, .rsp_ready
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // One access per line, '#' lines are comments
  task automatic load_vectors;
    int          fd;
    int          n;
    string       line;
    logic [31:0] st, f3, addr, wd, ed, ee;
    fd = $fopen("sim/lsu_mem_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/lsu_mem_input.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h", st, f3, addr, wd, ed, ee);
        if (n == 6) begin
          vec_req.push_back({addr, wd, f3[2:0], st[0]});  // Same field order as mem_req_t
          vec_exp.push_back({ed, ee[0]});
        end
      end
    end
    $fclose(fd);
    n_vec = vec_req.size();
  endtask

  // Back-to-back requests, held until accepted
  task automatic drive_requests;
    logic taken;
    @(posedge clk);
    #2;
    for (int i = 0; i < n_vec; i++) begin
      req_valid = 1'b1;
      req       = vec_req[i];
      taken     = 1'b0;
      while (!taken) begin
        @(negedge clk);  // req_ready stable mid-cycle
        taken = req_ready;
        if (taken) begin
          exp_q.push_back(vec_exp[i]);
          idx_q.push_back(i);
        end else begin
          stall_cycles++;
        end
        @(posedge clk);
        #2;
      end
    end
    req_valid = 1'b0;
    req       = '0;
  endtask

  // Random rsp_ready, compare each response in order
  task automatic collect_responses;
    mem_rsp_t exp;
    int       idx;
    while (rsp_count < n_vec) begin
      @(posedge clk);
      #2;
      rsp_ready = (($random(seed) & 3) > 1);  // Ready about half the cycles
      @(negedge clk);
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t arrived with no request outstanding", $time);
          other_errs++;
        end else begin
          exp = exp_q.pop_front();
          idx = idx_q.pop_front();
          if (rsp.data !== exp.data) begin
            $display("FAIL t=%0t rsp.data (vector %0d) expected %08h got %08h",
                     $time, idx, exp.data, rsp.data);
            data_errs++;
          end
          if (rsp.err !== exp.err) begin
            $display("FAIL t=%0t rsp.err (vector %0d) expected %0b got %0b",
                     $time, idx, exp.err, rsp.err);
            flag_errs++;
          end
        end
        rsp_count++;
      end
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;
    fork
      drive_requests();
      collect_responses();
    join
    // Nothing more may come out once every vector is answered
    rsp_ready = 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (rsp_valid) begin
        $display("Extra response at %0t after all vectors were answered", $time);
        other_errs++;
      end
    end
    if (exp_q.size() != 0) begin
      $display("%0d accepted requests were never answered", exp_q.size());
      other_errs++;
    end
    if (stall_cycles == 0) begin
      $display("req_ready never dropped, back-pressure was not exercised");
      other_errs++;
    end
    $display("Vectors %0d, responses %0d, request stall cycles %0d",
             n_vec, rsp_count, stall_cycles);
    $display("Errors: data %0d, error flag %0d, other %0d", data_errs, flag_errs, other_errs);
    if (n_vec > 0 && data_errs + flag_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Twenty cycles per vector, plus reset
  initial begin
    wait (loaded);
    #((n_vec * 20 + 10) * CLK_PERIOD);
    $display("Timeout, %0d of %0d vectors got no response", n_vec - rsp_count, n_vec);
    $display("Errors: data %0d, error flag %0d, other %0d", data_errs, flag_errs, other_errs + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
